// ==== hdl/ks10_word_pkg.sv ====
/*
 * KS-10 data path word definitions
 * Data word and address sizing for the scratchpad slice.
 * Words use KS-10 bit order, so bit 0 is the most significant bit.
 */

package ks10_word_pkg;

   ////////////////////////////////////////
   // Word sizing
   ////////////////////////////////////////

   // Full KS-10 word
   localparam int WORD_WIDTH = 36;

   // Default address width of the RAM file, 1K words
   localparam int DEF_ADDR_WIDTH = 10;

   // One data word, bit 0 is the MSB as in the KS-10 prints
   typedef logic [0:WORD_WIDTH-1] word_t;

endpackage : ks10_word_pkg

// ==== hdl/ks10_op_pkg.sv ====
/*
 * KS-10 data path control vocabulary
 * Host command opcodes and the command controller states.
 */

package ks10_op_pkg;

   ////////////////////////////////////////
   // Host commands
   ////////////////////////////////////////

   // Three bits cover all seven commands, one code is spare
   typedef enum logic [2:0] {
      OP_WRITE = 3'd0,   // Store operand
      OP_READ  = 3'd1,   // Return stored word
      OP_ADD   = 3'd2,   // Stored word plus operand
      OP_SUB   = 3'd3,   // Stored word minus operand
      OP_AND   = 3'd4,
      OP_OR    = 3'd5,
      OP_XOR   = 3'd6
   } dp_op_e;

   ////////////////////////////////////////
   // Controller states
   ////////////////////////////////////////

   typedef enum logic [1:0] {
      ST_IDLE   = 2'd0,   // Waiting for a strobe
      ST_ACCESS = 2'd1,   // RAM write or read address capture
      ST_EXEC   = 2'd2,   // ALU result and write-back
      ST_DONE   = 2'd3    // Done pulse cycle
   } ctl_state_e;

endpackage : ks10_op_pkg

// ==== hdl/ram_if.sv ====
/*
 * Scratchpad RAM file bus
 * Enable, write, address and data between the command controller
 * and the 1Kx36 RAM file.
 */

`timescale 1ns/10ps

interface ram_if
   import ks10_word_pkg::*;
#(
   parameter int ADDR_WIDTH = DEF_ADDR_WIDTH
) ();

   logic                  clken;  // Clock enable, sampled on rising clk
   logic                  wr;     // Write, only counts with clken
   logic [0:ADDR_WIDTH-1] addr;   // Word address
   word_t                 din;    // Write data
   word_t                 dout;   // Word at last captured address

   // Controller side drives the access
   modport ctl (output clken, wr, addr, din, input dout);

   // Memory side answers it
   modport mem (input clken, wr, addr, din, output dout);

endinterface : ram_if

// ==== hdl/ram_file.sv ====
/*
 * Scratchpad RAM file
 * Synchronous single port RAM of 36-bit words. The read address is
 * registered under clock enable, so data follows one cycle later.
 * Writes land on the same enabled rising edge.
 */

`timescale 1ns/10ps

module ram_file
   import ks10_word_pkg::*;
#(
   parameter int ADDR_WIDTH = DEF_ADDR_WIDTH
) (
   input logic clk,
   ram_if.mem  m
);

   // Depth follows the address width
   localparam int DEPTH = 1 << ADDR_WIDTH;

   // Storage array, contents undefined until written
   word_t mem_q [0:DEPTH-1];

   // Address captured on the last enabled edge
   logic [0:ADDR_WIDTH-1] rd_addr_q;

   ////////////////////////////////////////
   // Write and read address capture
   ////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (m.clken)
      begin
         if (m.wr)
         begin
            mem_q[m.addr] <= m.din;
         end
         rd_addr_q <= m.addr;
      end
   end

   // Read port shows the stored word, including a word just written
   assign m.dout = mem_q[rd_addr_q];

   // The controller must never raise write outside an enabled access
   wr_needs_clken : assert property (@(posedge clk) $rose(m.wr) |-> m.clken)
      else $error("RAM write rose without clock enable");

endmodule : ram_file

// ==== hdl/alu36.sv ====
/*
 * 36-bit ALU
 * Combines the stored word with the host operand. Add and subtract
 * report carry or borrow out of bit 0, and zero flags an all zero
 * result.
 */

`timescale 1ns/10ps

module alu36
   import ks10_word_pkg::*;
   import ks10_op_pkg::*;
(
   input  dp_op_e op,      // Operation
   input  word_t  a,       // Stored word from the RAM file
   input  word_t  b,       // Host operand
   output word_t  y,       // Result
   output logic   carry,   // Carry out of bit 0, or borrow on subtract
   output logic   zero     // Result is all zeros
);

   // One extra bit ahead of bit 0 holds carry or borrow
   logic [0:WORD_WIDTH] sum_ext;

   ////////////////////////////////////////
   // Operation select
   ////////////////////////////////////////

   always_comb
   begin
      sum_ext = '0;
      y       = a;
      carry   = 1'b0;
      case (op)
         OP_WRITE: y = b;
         OP_READ:  y = a;
         OP_ADD:
         begin
            sum_ext = {1'b0, a} + {1'b0, b};
            y       = sum_ext[1:WORD_WIDTH];
            carry   = sum_ext[0];
         end
         OP_SUB:
         begin
            // Borrow shows up as the wrapped extra bit
            sum_ext = {1'b0, a} - {1'b0, b};
            y       = sum_ext[1:WORD_WIDTH];
            carry   = sum_ext[0];
         end
         OP_AND:   y = a & b;
         OP_OR:    y = a | b;
         OP_XOR:   y = a ^ b;
         // Spare code behaves like a read
         default:  y = a;
      endcase
   end

   // Zero flag for every operation
   assign zero = (y == '0);

endmodule : alu36

// ==== hdl/dp_ctl.sv ====
/*
 * Data path command controller
 * Latches one host command, sequences the RAM file access, the ALU
 * and the write-back, and holds the result and flag registers.
 */

`timescale 1ns/10ps

module dp_ctl
   import ks10_word_pkg::*;
   import ks10_op_pkg::*;
#(
   parameter int ADDR_WIDTH = DEF_ADDR_WIDTH
) (
   input  logic                  clk,
   input  logic                  rst,
   // Host command
   input  logic                  cmd_valid,
   input  dp_op_e                cmd_op,
   input  logic [0:ADDR_WIDTH-1] cmd_addr,
   input  word_t                 cmd_data,
   // Host status and result
   output logic                  busy,
   output logic                  done,
   output word_t                 result,
   output logic                  carry,
   output logic                  zero,
   // ALU
   output dp_op_e                alu_op,
   output word_t                 alu_b,
   input  word_t                 alu_y,
   input  logic                  alu_carry,
   input  logic                  alu_zero,
   // RAM file
   ram_if.ctl                    r
);

   ctl_state_e state_q;

   // Latched command
   dp_op_e                op_q;
   logic [0:ADDR_WIDTH-1] addr_q;
   word_t                 data_q;

   logic accept;
   logic is_alu;

   ////////////////////////////////////////
   // Command acceptance
   ////////////////////////////////////////

   // New strobe taken when idle or on the edge that ends done
   assign accept = cmd_valid && ((state_q == ST_IDLE) || (state_q == ST_DONE));

   // Ops that need the second cycle for write-back
   assign is_alu = (op_q != OP_WRITE) && (op_q != OP_READ);

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         op_q   <= cmd_op;
         addr_q <= cmd_addr;
         data_q <= cmd_data;
      end
   end

   ////////////////////////////////////////
   // State machine and result registers
   ////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state_q <= ST_IDLE;
         result  <= '0;
         carry   <= 1'b0;
         zero    <= 1'b0;
      end
      else
      begin
         case (state_q)
            ST_IDLE, ST_DONE:
            begin
               state_q <= accept ? ST_ACCESS : ST_IDLE;
            end
            ST_ACCESS:
            begin
               if (op_q == OP_WRITE)
               begin
                  // ALU passes the operand, so result shows the written word
                  state_q <= ST_DONE;
                  result  <= alu_y;
                  carry   <= alu_carry;
                  zero    <= alu_zero;
               end
               else
               begin
                  state_q <= ST_EXEC;
               end
            end
            ST_EXEC:
            begin
               // RAM word is valid now, ALU output is final
               state_q <= ST_DONE;
               result  <= alu_y;
               carry   <= alu_carry;
               zero    <= alu_zero;
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   ////////////////////////////////////////
   // RAM and ALU drive
   ////////////////////////////////////////

   // Access cycle writes or captures the address, exec writes back
   assign r.clken = (state_q == ST_ACCESS) || ((state_q == ST_EXEC) && is_alu);
   assign r.wr    = ((state_q == ST_ACCESS) && (op_q == OP_WRITE))
                  || ((state_q == ST_EXEC) && is_alu);
   assign r.addr  = addr_q;
   // Write data always comes through the ALU
   assign r.din   = alu_y;

   assign alu_op  = op_q;
   assign alu_b   = data_q;

   assign busy    = (state_q != ST_IDLE);
   assign done    = (state_q == ST_DONE);

   // Done is a single cycle pulse
   done_one_cycle : assert property (@(posedge clk) disable iff (rst) done |=> !done)
      else $error("done held longer than one cycle");

   // Every done closes a busy period
   done_after_busy : assert property (@(posedge clk) disable iff (rst) done |-> $past(busy))
      else $error("done without busy on the previous cycle");

endmodule : dp_ctl

// ==== hdl/dp_top.sv ====
/*
 * KS-10 scratchpad data path slice
 * Joins the command controller, the RAM file and the ALU behind a
 * strobe, busy and done host interface.
 */

`timescale 1ns/10ps

module dp_top
   import ks10_word_pkg::*;
   import ks10_op_pkg::*;
#(
   parameter int ADDR_WIDTH = DEF_ADDR_WIDTH
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  cmd_valid,   // One cycle strobe
   input  dp_op_e                cmd_op,
   input  logic [0:ADDR_WIDTH-1] cmd_addr,
   input  word_t                 cmd_data,
   output logic                  busy,        // Command in progress
   output logic                  done,        // One cycle completion pulse
   output word_t                 result,
   output logic                  carry,
   output logic                  zero
);

   // Controller to ALU
   dp_op_e alu_op;
   word_t  alu_b;
   word_t  alu_y;
   logic   alu_carry;
   logic   alu_zero;

   ram_if #(.ADDR_WIDTH(ADDR_WIDTH)) ram_bus ();

   ////////////////////////////////////////
   // Instances
   ////////////////////////////////////////

   dp_ctl #(.ADDR_WIDTH(ADDR_WIDTH)) ctl_i (
      .clk       (clk),
      .rst       (rst),
      .cmd_valid (cmd_valid),
      .cmd_op    (cmd_op),
      .cmd_addr  (cmd_addr),
      .cmd_data  (cmd_data),
      .busy      (busy),
      .done      (done),
      .result    (result),
      .carry     (carry),
      .zero      (zero),
      .alu_op    (alu_op),
      .alu_b     (alu_b),
      .alu_y     (alu_y),
      .alu_carry (alu_carry),
      .alu_zero  (alu_zero),
      .r         (ram_bus.ctl)
   );

   ram_file #(.ADDR_WIDTH(ADDR_WIDTH)) ram_i (
      .clk (clk),
      .m   (ram_bus.mem)
   );

   // Stored word comes straight from the RAM read port
   alu36 alu_i (
      .op    (alu_op),
      .a     (ram_bus.dout),
      .b     (alu_b),
      .y     (alu_y),
      .carry (alu_carry),
      .zero  (alu_zero)
   );

endmodule : dp_top

// ==== tests/dp_checker.sv ====
/*
 * Data path checker
 * Watches the host ports, keeps a shadow of the RAM file and compares
 * every completed command with the reference model.
 */

`timescale 1ns/10ps

module dp_checker
   import ks10_word_pkg::*;
   import ks10_op_pkg::*;
#(
   parameter int ADDR_WIDTH = DEF_ADDR_WIDTH
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  cmd_valid,
   input  dp_op_e                cmd_op,
   input  logic [0:ADDR_WIDTH-1] cmd_addr,
   input  word_t                 cmd_data,
   input  logic                  busy,
   input  logic                  done,
   input  word_t                 result,
   input  logic                  carry,
   input  logic                  zero,
   output int                    mismatch_count,
   output int                    other_count,
   output int                    checked_count,
   output logic                  pending
);

   localparam int DEPTH = 1 << ADDR_WIDTH;

   // Shadow of the RAM file and which words hold known data
   word_t shadow [0:DEPTH-1];
   logic  known  [0:DEPTH-1];

   // Command waiting for its done pulse
   dp_op_e                p_op;
   logic [0:ADDR_WIDTH-1] p_addr;
   word_t                 p_data;
   logic                  started;

   // Edges since the pending command was taken
   int                    age;

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////

   // Packs expected result, carry and zero as {y, carry, zero}
   function automatic logic [37:0] expected_outcome(input dp_op_e op, input word_t a,
                                                    input word_t b);
      word_t y;
      logic  c;
      logic  z;
      y = a;
      c = 1'b0;
      case (op)
         OP_WRITE: y = b;
         OP_ADD:
         begin
            y = a + b;
            // Wrapped sum below the stored word means carry out of bit 0
            c = (y < a);
         end
         OP_SUB:
         begin
            y = a - b;
            c = (b > a);   // borrow
         end
         OP_AND:   y = a & b;
         OP_OR:    y = a | b;
         OP_XOR:   y = a ^ b;
         default:  y = a;
      endcase
      z = (y == '0);
      return {y, c, z};
   endfunction

   task automatic compare_word(input string name, input word_t want, input word_t got);
      if (got !== want)
      begin
         mismatch_count++;
         $display("MISMATCH %s expected %h got %h", name, want, got);
      end
   endtask

   task automatic compare_flag(input string name, input logic want, input logic got);
      if (got !== want)
      begin
         mismatch_count++;
         $display("MISMATCH %s expected %h got %h", name, want, got);
      end
   endtask

   ////////////////////////////////////////
   // Port monitor
   ////////////////////////////////////////

   always @(posedge clk)
   begin
      logic [37:0] want;
      if (rst)
      begin
         for (int i = 0; i < DEPTH; i++)
         begin
            known[i] = 1'b0;
         end
         mismatch_count = 0;
         other_count    = 0;
         checked_count  = 0;
         pending        = 1'b0;
         started        = 1'b0;
         age            = 0;
      end
      else
      begin
         // Busy covers every cycle from the strobe to the end of done
         compare_flag("busy", pending, busy);
         if (pending)
         begin
            age++;
            // Write finishes one edge sooner than read and the ALU ops
            compare_flag("done", age == ((p_op == OP_WRITE) ? 2 : 3), done);
         end
         // Quiet outputs between reset and the first command
         if (!started)
         begin
            compare_flag("done", 1'b0, done);
            compare_word("result", '0, result);
            compare_flag("carry", 1'b0, carry);
            compare_flag("zero", 1'b0, zero);
         end
         if (done)
         begin
            if (!pending)
            begin
               other_count++;
               $display("Done pulse seen with no command pending");
            end
            else
            begin
               if ((p_op != OP_WRITE) && !known[p_addr])
               begin
                  other_count++;
                  $display("Command used address %h before it was written", p_addr);
               end
               want = expected_outcome(p_op, shadow[p_addr], p_data);
               compare_word("result", want[37:2], result);
               compare_flag("carry", want[1], carry);
               compare_flag("zero", want[0], zero);
               // Everything but READ writes its result back
               if (p_op != OP_READ)
               begin
                  shadow[p_addr] = want[37:2];
                  known[p_addr]  = 1'b1;
               end
               pending = 1'b0;
               checked_count++;
            end
         end
         // Strobe is taken when idle or on the edge that ends done
         if (cmd_valid && (!busy || done))
         begin
            if (pending)
            begin
               other_count++;
               $display("New command accepted while the previous one had not finished");
            end
            p_op    = cmd_op;
            p_addr  = cmd_addr;
            p_data  = cmd_data;
            pending = 1'b1;
            started = 1'b1;
            age     = 0;
         end
      end
   end

endmodule : dp_checker

// ==== tests/tb_dp.sv ====
/*
 * Testbench for the KS-10 scratchpad data path slice
 * Directed write, read and ALU commands, then a seeded random run.
 */

`timescale 1ns/10ps

module tb_dp
   import ks10_word_pkg::*;
   import ks10_op_pkg::*;
();

   localparam int ADDR_WIDTH    = DEF_ADDR_WIDTH;
   localparam int CLK_PERIOD    = 20;
   localparam int DIRECTED_CMDS = 26;
   localparam int RAND_ADDRS    = 16;
   localparam int RAND_CMDS     = 200;
   localparam int NUM_CMDS      = DIRECTED_CMDS + RAND_ADDRS + RAND_CMDS;
   // Six cycles per command plus a reset margin
   localparam int WATCHDOG_NS   = NUM_CMDS * 6 * CLK_PERIOD + 20 * CLK_PERIOD;

   logic                  clk;
   logic                  rst;
   logic                  cmd_valid;
   dp_op_e                cmd_op;
   logic [0:ADDR_WIDTH-1] cmd_addr;
   word_t                 cmd_data;
   logic                  busy;
   logic                  done;
   word_t                 result;
   logic                  carry;
   logic                  zero;

   int     mismatch_count;
   int     other_count;
   int     checked_count;
   logic   pending;
   int     issued;
   int     errors;
   integer seed;

   // Address set of the random run
   logic [0:ADDR_WIDTH-1] rand_addr [0:RAND_ADDRS-1];

   dp_top #(.ADDR_WIDTH(ADDR_WIDTH)) dp_top_i (
      .clk (clk), .rst (rst), .cmd_valid (cmd_valid), .cmd_op (cmd_op),
      .cmd_addr (cmd_addr), .cmd_data (cmd_data), .busy (busy), .done (done),
      .result (result), .carry (carry), .zero (zero)
   );

   dp_checker #(.ADDR_WIDTH(ADDR_WIDTH)) check_i (
      .clk (clk), .rst (rst), .cmd_valid (cmd_valid), .cmd_op (cmd_op),
      .cmd_addr (cmd_addr), .cmd_data (cmd_data), .busy (busy), .done (done),
      .result (result), .carry (carry), .zero (zero),
      .mismatch_count (mismatch_count), .other_count (other_count),
      .checked_count (checked_count), .pending (pending)
   );

   ////////////////////////////////////////
   // Clock and watchdog
   ////////////////////////////////////////

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("Run timed out after %0d ns before all commands completed", WATCHDOG_NS);
      $display("TEST FAIL");
      $finish;
   end

   ////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////

   // Called on a falling edge, returns on the falling edge inside done
   task automatic issue(input dp_op_e op, input logic [0:ADDR_WIDTH-1] addr,
                        input word_t data);
      cmd_valid = 1'b1;
      cmd_op    = op;
      cmd_addr  = addr;
      cmd_data  = data;
      @(negedge clk);
      cmd_valid = 1'b0;
      issued++;
      while (!done)
      begin
         @(negedge clk);
      end
   endtask

   function automatic word_t random_word();
      logic [31:0] hi;
      logic [31:0] lo;
      hi = $random(seed);
      lo = $random(seed);
      return {hi[3:0], lo};
   endfunction

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////

   initial
   begin
      logic [31:0] r;
      dp_op_e      op;
      seed      = 32'h5abe46c0;
      issued    = 0;
      errors    = 0;
      rst       = 1'b1;
      cmd_valid = 1'b0;
      cmd_op    = OP_READ;
      cmd_addr  = '0;
      cmd_data  = '0;
      repeat (4) @(negedge clk);
      rst = 1'b0;
      // Idle outputs get checked over these cycles
      repeat (3) @(negedge clk);

      // Edge addresses and single bit words
      issue(OP_WRITE, '0, 36'h800000000);
      issue(OP_WRITE, '1, 36'h000000001);
      issue(OP_WRITE, 10'd5, 36'h123456789);
      issue(OP_WRITE, 10'd512, 36'hFEDCBA987);
      issue(OP_READ, '0, '0);
      issue(OP_READ, '1, '0);
      issue(OP_READ, 10'd5, '0);
      issue(OP_READ, 10'd512, '0);

      // ADD without and with carry, then read back
      issue(OP_WRITE, 10'd10, 36'h000001234);
      issue(OP_ADD, 10'd10, 36'h000000010);
      issue(OP_READ, 10'd10, '0);
      issue(OP_WRITE, 10'd11, 36'hFFFFFFFF0);
      issue(OP_ADD, 10'd11, 36'h000000020);
      issue(OP_READ, 10'd11, '0);

      // SUB to zero and SUB with borrow
      issue(OP_WRITE, 10'd20, 36'h0000ABCDE);
      issue(OP_SUB, 10'd20, 36'h0000ABCDE);
      issue(OP_WRITE, 10'd21, 36'h000000005);
      issue(OP_SUB, 10'd21, 36'h000000009);
      issue(OP_READ, 10'd21, '0);

      // Logic ops chained on one word
      issue(OP_WRITE, 10'd30, 36'hF0F0F0F0F);
      issue(OP_AND, 10'd30, 36'h0FF00FF00);
      issue(OP_READ, 10'd30, '0);
      issue(OP_OR, 10'd30, 36'h00000FFFF);
      issue(OP_READ, 10'd30, '0);
      issue(OP_XOR, 10'd30, 36'hAAAAAAAAA);
      issue(OP_READ, 10'd30, '0);

      // Random run, low four address bits keep the set distinct
      for (int i = 0; i < RAND_ADDRS; i++)
      begin
         r = $random(seed);
         rand_addr[i] = ADDR_WIDTH'({r[5:0], i[3:0]});
         issue(OP_WRITE, rand_addr[i], random_word());
      end
      for (int n = 0; n < RAND_CMDS; n++)
      begin
         r = $random(seed);
         // Spare opcode folds onto READ
         op = (r[2:0] == 3'd7) ? OP_READ : dp_op_e'(r[2:0]);
         issue(op, rand_addr[r[7:4]], random_word());
      end

      repeat (3) @(negedge clk);
      errors = mismatch_count + other_count;
      if (pending)
      begin
         errors++;
         $display("A command was still waiting for done at the end of the run");
      end
      if (checked_count != issued)
      begin
         errors++;
         $display("Checked %0d commands but issued %0d", checked_count, issued);
      end
      $display("Errors: %0d total, %0d mismatches, %0d other, over %0d commands",
               errors, mismatch_count, other_count, issued);
      if (errors == 0)
      begin
         $display("TEST PASS");
      end
      else
      begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule : tb_dp

// ==== sources.f ====
hdl/ks10_word_pkg.sv
hdl/ks10_op_pkg.sv
hdl/ram_if.sv
hdl/ram_file.sv
hdl/alu36.sv
hdl/dp_ctl.sv
hdl/dp_top.sv
tests/dp_checker.sv
tests/tb_dp.sv

// ==== Makefile ====
# Verilator build and run of the KS-10 scratchpad data path testbench

VERILATOR ?= verilator
TOP       ?= tb_dp
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/10ps
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TEST PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR TIMESCALE VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
